// ==== hw/lsu_iq_pkg.sv ====
package lsu_iq_pkg;

    // queue geometry
    localparam int IQ_DEPTH = 4;
    localparam int DISP_W   = 2;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  tag_t;
    typedef logic [1:0]  slot_t;
    // higher value is older
    typedef logic [1:0]  rank_t;
    // free entry count, 0 .. IQ_DEPTH
    typedef logic [2:0]  cnt_t;
    typedef logic [1:0]  src_sel_t;

    // operand sources seen by the forwarding mux
    localparam src_sel_t SRC_STORED = 2'd0;
    localparam src_sel_t SRC_CDB0   = 2'd1;
    localparam src_sel_t SRC_CDB1   = 2'd2;

    typedef struct packed {
        tag_t  tag;
        logic  present;
        word_t data;
    } opnd_t;

    typedef struct packed {
        tag_t  rob_id;
        logic  is_store;
        word_t imm;
        opnd_t base;
        opnd_t sdata;
    } disp_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t data;
    } cdb_t;

    typedef struct packed {
        logic  ready;
        rank_t rank;
    } ent_req_t;

    typedef struct packed {
        tag_t     rob_id;
        logic     is_store;
        word_t    imm;
        word_t    base;
        word_t    sdata;
        src_sel_t base_src;
        src_sel_t sdata_src;
    } ent_pay_t;

    typedef struct packed {
        tag_t  rob_id;
        logic  is_store;
        word_t addr;
        word_t sdata;
    } iss_t;

endpackage

// ==== hw/iq_alloc.sv ====
`timescale 1ns/1ns

module iq_alloc import lsu_iq_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       flush_i,
    input  logic [DISP_W-1:0]          disp_valid_i,
    input  logic [IQ_DEPTH-1:0]        busy_i,
    input  logic                       issue_fire_i,
    output logic [IQ_DEPTH-1:0]        wr_o,
    output logic [IQ_DEPTH-1:0]        wr_port_o,
    output rank_t [IQ_DEPTH-1:0]       init_rank_o,
    output logic [1:0]                 n_acc_o,
    output logic                       disp_ready_o
);

    logic [DISP_W-1:0] acc;
    slot_t             slot0;
    slot_t             slot1;
    logic              slot0_found;
    logic              slot1_found;
    cnt_t              free_q;

    // -------------------------------------------------------------------------
    // slot search: lowest free for port 0, next free for port 1
    always_comb begin
        slot0       = '0;
        slot1       = '0;
        slot0_found = 1'b0;
        slot1_found = 1'b0;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (!busy_i[i]) begin
                if (!slot0_found) begin
                    slot0       = slot_t'(i);
                    slot0_found = 1'b1;
                end else if (!slot1_found) begin
                    slot1       = slot_t'(i);
                    slot1_found = 1'b1;
                end
            end
        end
    end

    // dispatches in a flush cycle are dropped
    assign acc     = disp_valid_i & {DISP_W{disp_ready_o & ~flush_i}};
    assign n_acc_o = {1'b0, acc[0]} + {1'b0, acc[1]};

    always_comb begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            wr_o[i]        = (acc[0] && slot0 == slot_t'(i)) || (acc[1] && slot1 == slot_t'(i));
            wr_port_o[i]   = acc[1] && slot1 == slot_t'(i);
            // port 0 is one step older than a same-cycle port 1
            init_rank_o[i] = (acc[0] && acc[1] && slot0 == slot_t'(i)) ? rank_t'(1) : '0;
        end
    end

    // -------------------------------------------------------------------------
    // free count
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            free_q <= cnt_t'(IQ_DEPTH);
        end else if (flush_i) begin
            free_q <= cnt_t'(IQ_DEPTH);
        end else begin
            free_q <= free_q - cnt_t'(n_acc_o) + cnt_t'(issue_fire_i);
        end
    end

    assign disp_ready_o = free_q >= cnt_t'(DISP_W);

endmodule

// ==== hw/iq_entry.sv ====
`timescale 1ns/1ns

module iq_entry import lsu_iq_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 flush_i,
    input  logic                 wr_i,
    input  logic                 wr_port_i,
    input  rank_t                init_rank_i,
    input  logic [1:0]           n_acc_i,
    input  disp_t [DISP_W-1:0]   disp_i,
    input  cdb_t [DISP_W-1:0]    cdb_i,
    input  logic                 issue_i,
    output logic                 busy_o,
    output ent_req_t             req_o,
    output ent_pay_t             pay_o
);

    logic       busy_q;
    rank_t      rank_q;
    disp_t      rec_q;
    disp_t      new_rec;
    src_sel_t   base_src;
    src_sel_t   sdata_src;
    logic       base_ok;
    logic       sdata_ok;
    logic [2:0] rank_sum;

    // broadcast port whose tag matches a pending operand, port 0 first
    function automatic src_sel_t wake_src(opnd_t op, cdb_t [DISP_W-1:0] cdb);
        src_sel_t src;
        src = SRC_STORED;
        if (!op.present) begin
            if (cdb[1].valid && cdb[1].tag == op.tag) src = SRC_CDB1;
            if (cdb[0].valid && cdb[0].tag == op.tag) src = SRC_CDB0;
        end
        return src;
    endfunction

    function automatic opnd_t capture(opnd_t op, cdb_t [DISP_W-1:0] cdb);
        opnd_t    res;
        src_sel_t src;
        res = op;
        src = wake_src(op, cdb);
        if (src != SRC_STORED) begin
            res.present = 1'b1;
            res.data    = (src == SRC_CDB1) ? cdb[1].data : cdb[0].data;
        end
        return res;
    endfunction

    assign new_rec   = disp_i[wr_port_i];
    assign base_src  = wake_src(rec_q.base, cdb_i);
    assign sdata_src = wake_src(rec_q.sdata, cdb_i);
    assign base_ok   = rec_q.base.present || base_src != SRC_STORED;
    // loads do not wait for store data
    assign sdata_ok  = !rec_q.is_store || rec_q.sdata.present || sdata_src != SRC_STORED;
    assign rank_sum  = {1'b0, rank_q} + {1'b0, n_acc_i};

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            rank_q <= '0;
        end else if (flush_i) begin
            busy_q <= 1'b0;
            rank_q <= '0;
        end else if (wr_i) begin
            busy_q <= 1'b1;
            rank_q <= init_rank_i;
        end else if (issue_i) begin
            busy_q <= 1'b0;
        end else if (busy_q) begin
            rank_q <= rank_sum[2] ? '1 : rank_sum[1:0];
        end
    end

    // operands keep waking while the slot is idle
    always_ff @(posedge clk) begin
        if (wr_i) begin
            rec_q       <= new_rec;
            rec_q.base  <= capture(new_rec.base, cdb_i);
            rec_q.sdata <= capture(new_rec.sdata, cdb_i);
        end else begin
            rec_q.base  <= capture(rec_q.base, cdb_i);
            rec_q.sdata <= capture(rec_q.sdata, cdb_i);
        end
    end

    assign busy_o        = busy_q;
    assign req_o.ready   = busy_q && base_ok && sdata_ok;
    assign req_o.rank    = rank_q;
    assign pay_o.rob_id    = rec_q.rob_id;
    assign pay_o.is_store  = rec_q.is_store;
    assign pay_o.imm       = rec_q.imm;
    assign pay_o.base      = rec_q.base.data;
    assign pay_o.sdata     = rec_q.sdata.data;
    assign pay_o.base_src  = base_src;
    assign pay_o.sdata_src = sdata_src;

endmodule

// ==== hw/iq_age_select.sv ====
`timescale 1ns/1ns

module iq_age_select import lsu_iq_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       flush_i,
    input  ent_req_t [IQ_DEPTH-1:0]    req_i,
    input  logic                       iss_ready_i,
    output logic [IQ_DEPTH-1:0]        issue_o,
    output slot_t                      sel_slot_o,
    output logic                       advance_o,
    output logic                       iss_valid_o
);

    ent_req_t [1:0] l1_req;
    slot_t [1:0]    l1_slot;
    logic           iss_valid_q;

    // true when b should win over a; ties go to a
    function automatic logic b_wins(ent_req_t a, ent_req_t b);
        return b.ready && (!a.ready || b.rank > a.rank);
    endfunction

    // -------------------------------------------------------------------------
    // compare tree, pairs first then the two pair winners
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            if (b_wins(req_i[2*p], req_i[2*p+1])) begin
                l1_slot[p] = slot_t'(2*p + 1);
                l1_req[p]  = req_i[2*p+1];
            end else begin
                l1_slot[p] = slot_t'(2*p);
                l1_req[p]  = req_i[2*p];
            end
        end
        sel_slot_o = b_wins(l1_req[0], l1_req[1]) ? l1_slot[1] : l1_slot[0];
    end

    // issue register empty or handing over this cycle
    assign advance_o = (l1_req[0].ready || l1_req[1].ready) && (!iss_valid_q || iss_ready_i);
    assign issue_o   = {{(IQ_DEPTH-1){1'b0}}, advance_o} << sel_slot_o;

    // -------------------------------------------------------------------------
    // issue valid
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            iss_valid_q <= 1'b0;
        end else if (flush_i) begin
            iss_valid_q <= 1'b0;
        end else if (advance_o) begin
            iss_valid_q <= 1'b1;
        end else if (iss_ready_i) begin
            iss_valid_q <= 1'b0;
        end
    end

    assign iss_valid_o = iss_valid_q;

endmodule

// ==== hw/iq_operand_fwd.sv ====
`timescale 1ns/1ns

module iq_operand_fwd import lsu_iq_pkg::*; (
    input  logic                       clk,
    input  slot_t                      sel_slot_i,
    input  logic                       advance_i,
    input  ent_pay_t [IQ_DEPTH-1:0]    pay_i,
    input  cdb_t [DISP_W-1:0]          cdb_i,
    output iss_t                       iss_o
);

    ent_pay_t sel_pay;
    word_t    base_w;
    word_t    sdata_w;
    iss_t     rec_d;
    iss_t     iss_q;

    function automatic word_t fwd_word(word_t stored, src_sel_t src, cdb_t [DISP_W-1:0] cdb);
        case (src)
            SRC_CDB0: return cdb[0].data;
            SRC_CDB1: return cdb[1].data;
            default:  return stored;
        endcase
    endfunction

    // -------------------------------------------------------------------------
    // late operands arrive straight from the broadcast ports
    always_comb begin
        sel_pay        = pay_i[sel_slot_i];
        base_w         = fwd_word(sel_pay.base, sel_pay.base_src, cdb_i);
        sdata_w        = fwd_word(sel_pay.sdata, sel_pay.sdata_src, cdb_i);
        rec_d.rob_id   = sel_pay.rob_id;
        rec_d.is_store = sel_pay.is_store;
        rec_d.addr     = base_w + sel_pay.imm;
        rec_d.sdata    = sdata_w;
    end

    // held while the consumer stalls
    always_ff @(posedge clk) begin
        if (advance_i) begin
            iss_q <= rec_d;
        end
    end

    assign iss_o = iss_q;

endmodule

// ==== hw/lsu_iq.sv ====
`timescale 1ns/1ns

module lsu_iq import lsu_iq_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic [DISP_W-1:0]      disp_valid_i,
    input  disp_t [DISP_W-1:0]     disp_i,
    input  logic                   flush_i,
    input  cdb_t [DISP_W-1:0]      cdb_i,
    input  logic                   iss_ready_i,
    output logic                   disp_ready_o,
    output logic                   iss_valid_o,
    output iss_t                   iss_o
);

    logic [IQ_DEPTH-1:0]     busy;
    logic [IQ_DEPTH-1:0]     wr;
    logic [IQ_DEPTH-1:0]     wr_port;
    logic [IQ_DEPTH-1:0]     issue;
    rank_t [IQ_DEPTH-1:0]    init_rank;
    logic [1:0]              n_acc;
    ent_req_t [IQ_DEPTH-1:0] req;
    ent_pay_t [IQ_DEPTH-1:0] pay;
    slot_t                   sel_slot;
    logic                    advance;

    iq_alloc iq_alloc_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .disp_valid_i (disp_valid_i),
        .busy_i       (busy),
        .issue_fire_i (advance),
        .wr_o         (wr),
        .wr_port_o    (wr_port),
        .init_rank_o  (init_rank),
        .n_acc_o      (n_acc),
        .disp_ready_o (disp_ready_o)
    );

    // -------------------------------------------------------------------------
    // queue slots
    for (genvar i = 0; i < IQ_DEPTH; i++) begin : g_entry
        iq_entry iq_entry_i (
            .clk         (clk),
            .rst_n_i     (rst_n_i),
            .flush_i     (flush_i),
            .wr_i        (wr[i]),
            .wr_port_i   (wr_port[i]),
            .init_rank_i (init_rank[i]),
            .n_acc_i     (n_acc),
            .disp_i      (disp_i),
            .cdb_i       (cdb_i),
            .issue_i     (issue[i]),
            .busy_o      (busy[i]),
            .req_o       (req[i]),
            .pay_o       (pay[i])
        );
    end

    iq_age_select iq_age_select_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .req_i       (req),
        .iss_ready_i (iss_ready_i),
        .issue_o     (issue),
        .sel_slot_o  (sel_slot),
        .advance_o   (advance),
        .iss_valid_o (iss_valid_o)
    );

    iq_operand_fwd iq_operand_fwd_i (
        .clk        (clk),
        .sel_slot_i (sel_slot),
        .advance_i  (advance),
        .pay_i      (pay),
        .cdb_i      (cdb_i),
        .iss_o      (iss_o)
    );

endmodule

// ==== bench/tb_clk_gen.sv ====
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // 4 ns period
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // reset held low for 16 rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (16) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

// ==== bench/lsu_iq_tb.sv ====
`timescale 1ns/1ns

module lsu_iq_tb import lsu_iq_pkg::*; ();

    localparam int N_TAG     = 16;
    localparam int N_CYCLES  = 4000;
    localparam int RST_MAX   = 64;
    localparam int DRAIN_MAX = 256;

    // one outstanding instruction of the reference model
    typedef struct packed {
        logic        live;
        logic        known;
        logic        ordered;
        logic [31:0] age;
        logic        base_wait;
        logic        sd_wait;
        tag_t        base_tag;
        tag_t        sd_tag;
        logic        is_st;
        word_t       imm;
        word_t       base;
        word_t       sd;
    } mdl_t;

    logic               clk;
    logic               rst_n;
    logic [DISP_W-1:0]  disp_valid;
    disp_t [DISP_W-1:0] disp;
    logic               flush;
    cdb_t [DISP_W-1:0]  cdb;
    logic               iss_ready;
    logic               disp_ready;
    logic               iss_valid;
    iss_t               iss;

    integer seed;
    int     err_cnt;
    int     chk_cnt;

    // reference model, indexed by rob id
    mdl_t   mdl      [N_TAG];
    iss_t   exp_tab  [N_TAG];
    // producer tags still waiting for their broadcast
    logic   tag_pend [N_TAG];
    word_t  tag_val  [N_TAG];

    int     free_cnt;
    int     n_live;
    int     seq;
    int     acc_cnt;
    logic   prev_valid;
    logic   prev_ready;
    logic   prev_flush;
    iss_t   prev_iss;
    logic   rst_seen;
    logic   drain_ok;

    tb_clk_gen tb_clk_gen_i (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    lsu_iq lsu_iq_i (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .disp_valid_i (disp_valid),
        .disp_i       (disp),
        .flush_i      (flush),
        .cdb_i        (cdb),
        .iss_ready_i  (iss_ready),
        .disp_ready_o (disp_ready),
        .iss_valid_o  (iss_valid),
        .iss_o        (iss)
    );

    function automatic logic one_in(int n);
        return ($unsigned($random(seed)) % n) == 0;
    endfunction

    task automatic check_bit(input string name, input logic exp, input logic act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("[FAIL] %s: expected %0b, actual %0b", name, exp, act);
        end
    endtask

    task automatic check_iss(input string name, input iss_t exp, input iss_t act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // ------------------------------------------------------------------------
    // reference model
    task automatic clear_model();
        for (int k = 0; k < N_TAG; k++) begin
            mdl[k].live = 1'b0;
            tag_pend[k] = 1'b0;
        end
        n_live = 0;
    endtask

    // expected record once every operand value is known
    task automatic refresh(input int r);
        mdl[r].known = !mdl[r].base_wait && !mdl[r].sd_wait;
        if (mdl[r].known) begin
            exp_tab[r].rob_id   = tag_t'(r);
            exp_tab[r].is_store = mdl[r].is_st;
            exp_tab[r].addr     = mdl[r].base + mdl[r].imm;
            exp_tab[r].sdata    = mdl[r].sd;
        end
    endtask

    task automatic wake(input tag_t t);
        for (int k = 0; k < N_TAG; k++) begin
            if (mdl[k].live && mdl[k].base_wait && mdl[k].base_tag == t) begin
                mdl[k].base      = tag_val[t];
                mdl[k].base_wait = 1'b0;
            end
            if (mdl[k].live && mdl[k].sd_wait && mdl[k].sd_tag == t) begin
                mdl[k].sd      = tag_val[t];
                mdl[k].sd_wait = 1'b0;
            end
            refresh(k);
        end
        tag_pend[t] = 1'b0;
    endtask

    task automatic make_operand(output opnd_t op, output logic pend);
        op.tag     = tag_t'($random(seed));
        op.data    = $random(seed);
        pend       = one_in(3);
        op.present = !pend;
        // first waiter on a tag fixes the value it will carry
        if (pend && !tag_pend[op.tag]) begin
            tag_pend[op.tag] = 1'b1;
            tag_val[op.tag]  = $random(seed);
        end
    endtask

    task automatic dispatch_one(input int port);
        disp_t d;
        logic  bw;
        logic  sw;
        logic  any_pend;
        int    r;
        r        = seq % N_TAG;
        any_pend = 1'b0;
        for (int k = 0; k < N_TAG; k++) begin
            if (mdl[k].live && !mdl[k].known) any_pend = 1'b1;
        end
        d.rob_id   = tag_t'(r);
        d.is_store = one_in(2);
        d.imm      = $random(seed);
        make_operand(d.base, bw);
        if (d.is_store) begin
            make_operand(d.sdata, sw);
        end else begin
            // loads carry a present store-data word
            d.sdata.tag     = tag_t'($random(seed));
            d.sdata.present = 1'b1;
            d.sdata.data    = $random(seed);
            sw              = 1'b0;
        end
        mdl[r].live      = 1'b1;
        mdl[r].age       = seq;
        mdl[r].base_wait = bw;
        mdl[r].sd_wait   = sw;
        mdl[r].base_tag  = d.base.tag;
        mdl[r].sd_tag    = d.sdata.tag;
        mdl[r].is_st     = d.is_store;
        mdl[r].imm       = d.imm;
        mdl[r].base      = d.base.data;
        mdl[r].sd        = d.sdata.data;
        refresh(r);
        mdl[r].ordered   = mdl[r].known && !any_pend;
        seq++;
        n_live++;
        acc_cnt++;
        disp[port]       = d;
        disp_valid[port] = 1'b1;
    endtask

    task automatic broadcast(input int port);
        int   start;
        tag_t t;
        start = $unsigned($random(seed)) % N_TAG;
        for (int k = 0; k < N_TAG; k++) begin
            t = tag_t'(start + k);
            if (tag_pend[t] && !cdb[port].valid) begin
                cdb[port].valid = 1'b1;
                cdb[port].tag   = t;
                cdb[port].data  = tag_val[t];
                wake(t);
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // per-cycle observation and stimulus, 1 ns after the rising edge
    task automatic observe_edge();
        int   r;
        logic loaded;
        if (prev_flush) begin
            check_bit("flush_iss_valid", 1'b0, iss_valid);
            check_bit("flush_disp_ready", 1'b1, disp_ready);
            free_cnt = IQ_DEPTH;
        end else begin
            loaded = (iss_valid === 1'b1) && (!prev_valid || prev_ready);
            if (prev_valid && !prev_ready) begin
                check_bit("hold_valid", 1'b1, iss_valid);
                check_iss("hold_record", prev_iss, iss);
            end
            if (loaded) begin
                r = int'(iss.rob_id);
                if (!mdl[r].live) begin
                    err_cnt++;
                    $display("rob id %0d issued while not outstanding", r);
                end else if (!mdl[r].known) begin
                    err_cnt++;
                    $display("rob id %0d issued before its operands were broadcast", r);
                end else begin
                    check_iss("issue_record", exp_tab[r], iss);
                    for (int k = 0; k < N_TAG; k++) begin
                        if (mdl[r].ordered && mdl[k].live && mdl[k].ordered &&
                            mdl[k].age < mdl[r].age) begin
                            err_cnt++;
                            $display("rob id %0d issued ahead of older rob id %0d", r, k);
                        end
                    end
                    mdl[r].live = 1'b0;
                    n_live--;
                end
            end
            free_cnt = free_cnt - acc_cnt + (loaded ? 1 : 0);
            check_bit("disp_ready", free_cnt >= DISP_W, disp_ready);
        end
    endtask

    task automatic drive_cycle(input logic active);
        disp_valid = '0;
        cdb        = '0;
        flush      = 1'b0;
        acc_cnt    = 0;
        if (active && one_in(80)) begin
            flush     = 1'b1;
            iss_ready = 1'b0;
            clear_model();
        end else begin
            iss_ready = active ? !one_in(3) : 1'b1;
            if (active && disp_ready) begin
                for (int p = 0; p < DISP_W; p++) begin
                    if (one_in(2)) dispatch_one(p);
                end
            end
            for (int p = 0; p < DISP_W; p++) begin
                if (!active || one_in(3)) broadcast(p);
            end
        end
    endtask

    task automatic save_prev();
        prev_valid = (iss_valid === 1'b1);
        prev_ready = iss_ready;
        prev_flush = flush;
        prev_iss   = iss;
    endtask

    // ------------------------------------------------------------------------
    initial begin
        seed       = 32'hd4fe;
        err_cnt    = 0;
        chk_cnt    = 0;
        disp_valid = '0;
        disp       = '0;
        flush      = 1'b0;
        cdb        = '0;
        iss_ready  = 1'b0;
        free_cnt   = IQ_DEPTH;
        seq        = 0;
        acc_cnt    = 0;
        prev_valid = 1'b0;
        prev_ready = 1'b0;
        prev_flush = 1'b0;
        prev_iss   = '0;
        drain_ok   = 1'b0;
        rst_seen   = 1'b0;
        clear_model();
        for (int n = 0; n < RST_MAX && !rst_seen; n++) begin
            @(posedge clk);
            rst_seen = (rst_n === 1'b1);
        end
        if (rst_seen) begin
            #1;
            check_bit("reset_iss_valid", 1'b0, iss_valid);
            check_bit("reset_disp_ready", 1'b1, disp_ready);
            repeat (N_CYCLES) begin
                @(posedge clk);
                #1;
                observe_edge();
                drive_cycle(1'b1);
                save_prev();
            end
            // drain, no flush, every waiting tag broadcast
            for (int n = 0; n < DRAIN_MAX && !drain_ok; n++) begin
                @(posedge clk);
                #1;
                observe_edge();
                drive_cycle(1'b0);
                save_prev();
                drain_ok = (n_live == 0) && (iss_valid !== 1'b1);
            end
            if (!drain_ok) begin
                err_cnt++;
                $display("drain timed out with %0d instructions not issued", n_live);
            end
        end else begin
            err_cnt++;
            $display("reset was not released within %0d cycles", RST_MAX);
        end
        $display("checks %0d, errors %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
hw/lsu_iq_pkg.sv
hw/iq_alloc.sv
hw/iq_entry.sv
hw/iq_age_select.sv
hw/iq_operand_fwd.sv
hw/lsu_iq.sv
bench/tb_clk_gen.sv
bench/lsu_iq_tb.sv

// ==== Bender.yml ====
package:
  name: lsu_iq

sources:
  # package first, then leaf blocks, then the top level
  - hw/lsu_iq_pkg.sv
  - hw/iq_alloc.sv
  - hw/iq_entry.sv
  - hw/iq_age_select.sv
  - hw/iq_operand_fwd.sv
  - hw/lsu_iq.sv

  - target: simulation
    files:
      - bench/tb_clk_gen.sv
      - bench/lsu_iq_tb.sv
